/* all.f */
source/rename_pkg.sv
source/inst_decoder.sv
source/rename_table.sv
source/phys_regfile.sv
source/decode_rename.sv
tests/decode_rename_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module decode_rename_tb \
	-f all.f -o decode_rename_sim &&
	./obj_dir/decode_rename_sim | tee sim.log

grep -qx "Testbench passed" sim.log 2>/dev/null && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

/* tests/decode_rename_tb.sv */
// decode and rename testbench
`timescale 1ns/100ps

module decode_rename_tb import rename_pkg::*; ();

	localparam int   ways      = 2;
	localparam logic rdy       = 1'b1;
	localparam logic busy      = 1'b0;
	localparam int   cdb_value = 32'h1234_5678;

	// major opcodes from the RV32 encoding tables
	localparam int op_r   = 'h33;
	localparam int op_i   = 'h13;
	localparam int op_ld  = 'h03;
	localparam int op_st  = 'h23;
	localparam int op_br  = 'h63;
	localparam int op_jal = 'h6f;
	localparam int op_lui = 'h37;

	typedef struct packed {
		logic            valid;
		prn_t            dest;
		logic            ra;
		logic            rb;
		logic [xlen-1:0] va;
		logic [xlen-1:0] vb;
		alu_func_e       func;
		opa_sel_e        opa;
		opb_sel_e        opb;
	} way_exp_t;

	typedef struct packed {
		logic [ways-1:0][31:0] inst;
		logic [ways-1:0]       iv;
		logic [ways-1:0]       pred;
		cdb_packet_t           cdb;   // driven on way 0 only
		retire_packet_t        ret;
		logic                  except;
		logic                  stall;
		way_exp_t [ways-1:0]   want;
	} row_t;

	logic                      clock;
	logic                      rst_n;
	if_id_packet_t [ways-1:0]  if_id_packet_in;
	logic [ways-1:0]           predictions;
	cdb_packet_t [ways-1:0]    cdb_in;
	retire_packet_t [ways-1:0] retire_in;
	logic                      except;
	id_ex_packet_t [ways-1:0]  id_packet_out;
	logic                      rename_stall;

	row_t rows [$];
	int   check_count = 0;
	int   error_count = 0;
	int   cycle_count = 0;
	int   cycle_limit = 1000;   // replaced once the table is built

	decode_rename #(.ways(ways)) dut_i (
		.clock           (clock),
		.rst_n           (rst_n),
		.if_id_packet_in (if_id_packet_in),
		.predictions     (predictions),
		.cdb_in          (cdb_in),
		.retire_in       (retire_in),
		.except          (except),
		.id_packet_out   (id_packet_out),
		.rename_stall    (rename_stall)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// encoding and table helpers
	////////////////////////////////////////////////////////////

	// R, S and B formats share one field layout
	function automatic logic [31:0] pack_rsb(int f7, int rs2, int rs1, int f3, int rd, int op);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] pack_i(int imm, int rs1, int f3, int rd, int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] pack_uj(int imm, int rd, int op);
		return {imm[19:0], rd[4:0], op[6:0]};
	endfunction

	// byte address of way i in row k
	function automatic logic [31:0] fetch_pc(int k, int i);
		return 32'h1000 + 32'(8 * k + 4 * i);
	endfunction

	function automatic way_exp_t exp_way(int dest, logic ra, int va, logic rb, int vb,
		alu_func_e func, opa_sel_e opa, opb_sel_e opb);
		way_exp_t e;
		e.valid = 1'b1;
		e.dest  = dest[5:0];
		e.ra    = ra;
		e.va    = va;
		e.rb    = rb;
		e.vb    = vb;
		e.func  = func;
		e.opa   = opa;
		e.opb   = opb;
		return e;
	endfunction

	function automatic cdb_packet_t cdb_write(int prn, int data);
		cdb_packet_t c;
		c.prn   = prn[5:0];
		c.data  = data;
		c.valid = 1'b1;
		return c;
	endfunction

	function automatic retire_packet_t retire_map(int arn, int prn);
		retire_packet_t r;
		r.arn   = arn[4:0];
		r.prn   = prn[5:0];
		r.valid = 1'b1;
		return r;
	endfunction

	function automatic void add_row(logic [31:0] inst0, logic [31:0] inst1, logic [1:0] iv,
		logic [1:0] pred, cdb_packet_t cdb, retire_packet_t ret, logic exc, logic stall,
		way_exp_t w0, way_exp_t w1);
		row_t r;
		r.inst[0] = inst0;
		r.inst[1] = inst1;
		r.iv      = iv;
		r.pred    = pred;
		r.cdb     = cdb;
		r.ret     = ret;
		r.except  = exc;
		r.stall   = stall;
		r.want[0] = w0;
		r.want[1] = w1;
		rows.push_back(r);
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	function automatic void build_table();
		logic [31:0] addi_x17;
		logic [31:0] addi_x18;
		way_exp_t    off;
		addi_x17 = pack_i(1, 0, 0, 17, op_i);
		addi_x18 = pack_i(1, 0, 0, 18, op_i);
		off      = '0;

		add_row(0, 0, 2'b00, 2'b00, '0, '0, 1'b0, 1'b0, off, off);   // idle after reset
		// add x5,x1,x2 ; sub x6,x5,x3
		add_row(pack_rsb(0, 2, 1, 0, 5, op_r), pack_rsb('h20, 3, 5, 0, 6, op_r),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(32, rdy, 0, rdy, 0, alu_add, opa_rs1, opb_rs2),
			exp_way(33, busy, 32, rdy, 0, alu_sub, opa_rs1, opb_rs2));
		// addi x7,x5,4 ; lw x8,0(x6) ; tag 32 written on the cdb
		add_row(pack_i(4, 5, 0, 7, op_i), pack_i(0, 6, 2, 8, op_ld),
			2'b11, 2'b00, cdb_write(32, cdb_value), '0, 1'b0, 1'b0,
			exp_way(34, busy, 32, rdy, 0, alu_add, opa_rs1, opb_i_imm),
			exp_way(35, busy, 33, rdy, 0, alu_add, opa_rs1, opb_i_imm));
		// sw x5,8(x6) ; add x9,x0,x5
		add_row(pack_rsb(0, 5, 6, 2, 8, op_st), pack_rsb(0, 5, 0, 0, 9, op_r),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(0, busy, 33, rdy, cdb_value, alu_add, opa_rs1, opb_s_imm),
			exp_way(36, rdy, 0, rdy, cdb_value, alu_add, opa_rs1, opb_rs2));
		// beq x1,x2,+16 predicted taken ; lui is wrong path
		add_row(pack_rsb(0, 2, 1, 0, 16, op_br), pack_uj('h12345, 10, op_lui),
			2'b11, 2'b01, '0, '0, 1'b0, 1'b0,
			exp_way(0, rdy, 0, rdy, 0, alu_add, opa_pc, opb_b_imm), off);
		// jal x11,+8 ; lui x10,0x12345
		add_row(pack_uj('h00800, 11, op_jal), pack_uj('h12345, 10, op_lui),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(37, rdy, 0, rdy, 0, alu_add, opa_pc, opb_j_imm),
			exp_way(38, rdy, 0, rdy, 0, alu_add, opa_zero, opb_u_imm));
		// mul x12,x5,x9 ; unknown opcode
		add_row(pack_rsb(1, 9, 5, 0, 12, op_r), 32'h0000_007f,
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(39, rdy, cdb_value, busy, 36, alu_mul, opa_rs1, opb_rs2), off);
		// wfi ; addi x13,x0,1
		add_row(32'h1050_0073, pack_i(1, 0, 0, 13, op_i),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			off, exp_way(40, rdy, 0, rdy, 0, alu_add, opa_rs1, opb_i_imm));

		// retire x5 to 32, rename x5 again, then flush
		add_row(0, 0, 2'b00, 2'b00, '0, retire_map(5, 32), 1'b0, 1'b0, off, off);
		add_row(pack_i(1, 5, 0, 5, op_i), pack_rsb(0, 0, 5, 0, 14, op_r),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(5, rdy, cdb_value, rdy, 0, alu_add, opa_rs1, opb_i_imm),
			exp_way(41, busy, 5, rdy, 0, alu_add, opa_rs1, opb_rs2));
		add_row(0, 0, 2'b00, 2'b00, '0, '0, 1'b1, 1'b0, off, off);
		// add x15,x5,x0 ; add x16,x15,x5 after recovery
		add_row(pack_rsb(0, 0, 5, 0, 15, op_r), pack_rsb(0, 5, 15, 0, 16, op_r),
			2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(5, rdy, cdb_value, rdy, 0, alu_add, opa_rs1, opb_rs2),
			exp_way(33, busy, 5, rdy, cdb_value, alu_add, opa_rs1, opb_rs2));

		// drain tags 34 to 63 two at a time
		for (int k = 0; k < 15; k++) begin
			add_row(addi_x17, addi_x18, 2'b11, 2'b00, '0, '0, 1'b0, 1'b0,
				exp_way(34 + 2 * k, rdy, 0, rdy, 0, alu_add, opa_rs1, opb_i_imm),
				exp_way(35 + 2 * k, rdy, 0, rdy, 0, alu_add, opa_rs1, opb_i_imm));
		end
		add_row(addi_x17, addi_x18, 2'b11, 2'b00, '0, retire_map(16, 33), 1'b0, 1'b1, off, off);
		add_row(addi_x17, addi_x18, 2'b11, 2'b00, '0, '0, 1'b0, 1'b1, off, off);   // one short
		add_row(addi_x17, addi_x18, 2'b01, 2'b00, '0, '0, 1'b0, 1'b0,
			exp_way(16, rdy, 0, rdy, 0, alu_add, opa_rs1, opb_i_imm), off);
	endfunction

	////////////////////////////////////////////////////////////
	// drive and check
	////////////////////////////////////////////////////////////

	task automatic apply_row(input int k);
		for (int i = 0; i < ways; i++) begin
			if_id_packet_in[i].inst  = rows[k].inst[i];
			if_id_packet_in[i].pc    = fetch_pc(k, i);
			if_id_packet_in[i].npc   = if_id_packet_in[i].pc + 32'd4;
			if_id_packet_in[i].valid = rows[k].iv[i];
		end
		predictions  = rows[k].pred;
		cdb_in[0]    = rows[k].cdb;
		cdb_in[1]    = '0;
		retire_in[0] = rows[k].ret;
		retire_in[1] = '0;
		except       = rows[k].except;
	endtask

	task automatic check_value(input int k, input string name, input logic [31:0] got,
		input logic [31:0] want);
		check_count++;
		assert (got === want) else begin
			error_count++;
			$display("error at %0t ns: row %0d %s = %h, expected %h", $time, k, name, got, want);
		end
	endtask

	task automatic check_row(input int k);
		string         way_name;
		id_ex_packet_t got;
		way_exp_t      want;
		check_value(k, "rename_stall", 32'(rename_stall), 32'(rows[k].stall));
		for (int i = 0; i < ways; i++) begin
			way_name = $sformatf("way %0d ", i);
			got      = id_packet_out[i];
			want     = rows[k].want[i];
			check_value(k, {way_name, "inst"}, got.inst, rows[k].inst[i]);
			check_value(k, {way_name, "pc"}, got.pc, fetch_pc(k, i));
			check_value(k, {way_name, "npc"}, got.npc, fetch_pc(k, i) + 32'd4);
			check_value(k, {way_name, "valid"}, 32'(got.valid), 32'(want.valid));
			check_value(k, {way_name, "ctl valid"}, 32'(got.ctl.valid), 32'(want.valid));
			if (want.valid) begin   // operand fields mean nothing on a dead way
				check_value(k, {way_name, "dest_prn"}, 32'(got.dest_prn), 32'(want.dest));
				check_value(k, {way_name, "opa_ready"}, 32'(got.opa_ready), 32'(want.ra));
				check_value(k, {way_name, "rs1_value"}, got.rs1_value, want.va);
				check_value(k, {way_name, "opb_ready"}, 32'(got.opb_ready), 32'(want.rb));
				check_value(k, {way_name, "rs2_value"}, got.rs2_value, want.vb);
				check_value(k, {way_name, "alu_func"}, 32'(got.ctl.alu_func), 32'(want.func));
				check_value(k, {way_name, "opa_sel"}, 32'(got.ctl.opa_sel), 32'(want.opa));
				check_value(k, {way_name, "opb_sel"}, 32'(got.ctl.opb_sel), 32'(want.opb));
			end
		end
	endtask

	initial begin
		clock           = 1'b0;
		rst_n           = 1'b0;
		if_id_packet_in = '0;
		predictions     = '0;
		cdb_in          = '0;
		retire_in       = '0;
		except          = 1'b0;

		build_table();
		cycle_limit = 2 * rows.size() + 20;

		repeat (3) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		for (int k = 0; k < rows.size(); k++) begin
			@(negedge clock);
			apply_row(k);
			#4;   // just before the rising edge
			check_row(k);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* source/decode_rename.sv */
// decode and rename stage
`timescale 1ns/100ps

module decode_rename import rename_pkg::*; #(
	parameter int ways = 2
) (
	input  logic                      clock,
	input  logic                      rst_n,
	input  if_id_packet_t [ways-1:0]  if_id_packet_in,
	input  logic [ways-1:0]           predictions,
	input  cdb_packet_t [ways-1:0]    cdb_in,
	input  retire_packet_t [ways-1:0] retire_in,
	input  logic                      except,
	output id_ex_packet_t [ways-1:0]  id_packet_out,
	output logic                      rename_stall
);

	decode_ctl_t [ways-1:0]       ctl;
	arn_t [ways-1:0]              src_a_arn;
	arn_t [ways-1:0]              src_b_arn;
	arn_t [ways-1:0]              dest_arn;
	prn_t [ways-1:0]              src_a_prn;
	prn_t [ways-1:0]              src_b_prn;
	prn_t [ways-1:0]              alloc_prn;
	logic [ways-1:0]              src_a_ready;
	logic [ways-1:0]              src_b_ready;
	logic [ways-1:0]              way_valid;   // after branch masking
	logic [ways-1:0]              alloc_req;
	logic [ways-1:0][xlen-1:0]    rd_a_data;
	logic [ways-1:0][xlen-1:0]    rd_b_data;

	// x0, prf value, or the tag of a producer still in flight
	function automatic void pick_operand(
		input  arn_t                arn,
		input  prn_t                prn,
		input  logic                rdy,
		input  logic [xlen-1:0]     data,
		input  logic                used,
		input  int                  way,
		input  logic [ways-1:0]     req,
		input  arn_t [ways-1:0]     darn,
		input  prn_t [ways-1:0]     dprn,
		output logic                ready,
		output logic [xlen-1:0]     value
	);
		ready = 1'b1;
		value = '0;
		if (used && arn != '0) begin
			ready = rdy;
			value = rdy ? data : xlen'(prn);
			// nearest older way in the bundle overrides the table
			for (int j = 0; j < ways; j++) begin
				if (j < way && req[j] && darn[j] == arn) begin
					ready = 1'b0;
					value = xlen'(dprn[j]);
				end
			end
		end
	endfunction

	for (genvar i = 0; i < ways; i++) begin : g_way
		inst_decoder decoder_i (
			.if_packet (if_id_packet_in[i]),
			.ctl       (ctl[i])
		);

		assign src_a_arn[i] = if_id_packet_in[i].inst.r.rs1;
		assign src_b_arn[i] = if_id_packet_in[i].inst.r.rs2;
		assign dest_arn[i]  = if_id_packet_in[i].inst.r.rd;
	end

	////////////////////////////////////////////////////////////
	// predicted-taken masking
	////////////////////////////////////////////////////////////

	always_comb begin
		logic taken;
		taken = 1'b0;
		for (int i = 0; i < ways; i++) begin
			way_valid[i] = ctl[i].valid & ~taken;
			alloc_req[i] = way_valid[i] && ctl[i].dest_sel == dest_rd && dest_arn[i] != '0;
			if (way_valid[i] && predictions[i]) begin
				taken = 1'b1;   // younger ways are wrong path
			end
		end
	end

	rename_table #(.ways(ways)) rename_table_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.except       (except),
		.src_a_arn    (src_a_arn),
		.src_b_arn    (src_b_arn),
		.dest_arn     (dest_arn),
		.alloc_req    (alloc_req),
		.cdb_in       (cdb_in),
		.retire_in    (retire_in),
		.src_a_prn    (src_a_prn),
		.src_b_prn    (src_b_prn),
		.src_a_ready  (src_a_ready),
		.src_b_ready  (src_b_ready),
		.dest_prn     (alloc_prn),
		.rename_stall (rename_stall)
	);

	phys_regfile #(.ways(ways)) phys_regfile_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_a_prn  (src_a_prn),
		.rd_b_prn  (src_b_prn),
		.cdb_in    (cdb_in),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data)
	);

	////////////////////////////////////////////////////////////
	// output packets
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			id_packet_out[i].inst      = if_id_packet_in[i].inst;
			id_packet_out[i].pc        = if_id_packet_in[i].pc;
			id_packet_out[i].npc       = if_id_packet_in[i].npc;
			id_packet_out[i].valid     = way_valid[i] & ~rename_stall;
			id_packet_out[i].ctl       = ctl[i];
			id_packet_out[i].ctl.valid = way_valid[i] & ~rename_stall;
			id_packet_out[i].dest_prn  = alloc_prn[i];   // 0 for x0 or no dest

			pick_operand(src_a_arn[i], src_a_prn[i], src_a_ready[i], rd_a_data[i],
				ctl[i].opa_sel == opa_rs1 || ctl[i].cond_branch,
				i, alloc_req, dest_arn, alloc_prn,
				id_packet_out[i].opa_ready, id_packet_out[i].rs1_value);

			// stores and branches read rs2 outside the opb select
			pick_operand(src_b_arn[i], src_b_prn[i], src_b_ready[i], rd_b_data[i],
				ctl[i].opb_sel == opb_rs2 || ctl[i].wr_mem || ctl[i].cond_branch,
				i, alloc_req, dest_arn, alloc_prn,
				id_packet_out[i].opb_ready, id_packet_out[i].rs2_value);
		end
	end

endmodule

/* source/phys_regfile.sv */
// physical register file
`timescale 1ns/100ps

module phys_regfile import rename_pkg::*; #(
	parameter int ways = 2
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  prn_t [ways-1:0]             rd_a_prn,
	input  prn_t [ways-1:0]             rd_b_prn,
	input  cdb_packet_t [ways-1:0]      cdb_in,
	output logic [ways-1:0][xlen-1:0]   rd_a_data,
	output logic [ways-1:0][xlen-1:0]   rd_b_data
);

	logic [xlen-1:0] regs [phys_regs];

	// no write bypass, a cdb value shows up the cycle after
	always_comb begin
		for (int i = 0; i < ways; i++) begin
			rd_a_data[i] = regs[rd_a_prn[i]];
			rd_b_data[i] = regs[rd_b_prn[i]];
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int p = 0; p < phys_regs; p++) begin
				regs[p] <= '0;
			end
		end else begin
			for (int i = 0; i < ways; i++) begin
				if (cdb_in[i].valid) begin
					regs[cdb_in[i].prn] <= cdb_in[i].data;   // higher way wins
				end
			end
		end
	end

endmodule

/* source/rename_table.sv */
// register alias tables and free pool
`timescale 1ns/100ps

module rename_table import rename_pkg::*; #(
	parameter int ways = 2
) (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      except,
	input  arn_t [ways-1:0]           src_a_arn,
	input  arn_t [ways-1:0]           src_b_arn,
	input  arn_t [ways-1:0]           dest_arn,
	input  logic [ways-1:0]           alloc_req,
	input  cdb_packet_t [ways-1:0]    cdb_in,
	input  retire_packet_t [ways-1:0] retire_in,
	output prn_t [ways-1:0]           src_a_prn,
	output prn_t [ways-1:0]           src_b_prn,
	output logic [ways-1:0]           src_a_ready,
	output logic [ways-1:0]           src_b_ready,
	output prn_t [ways-1:0]           dest_prn,
	output logic                      rename_stall
);

	prn_t [arch_regs-1:0] rat;
	prn_t [arch_regs-1:0] rat_next;
	prn_t [arch_regs-1:0] rrat;    // committed mapping
	prn_t [arch_regs-1:0] rrat_next;
	logic [phys_regs-1:0] ready;
	logic [phys_regs-1:0] ready_next;
	logic [phys_regs-1:0] free;
	logic [phys_regs-1:0] free_next;
	logic [ways-1:0]      granted;
	prn_t [ways-1:0]      grant_prn;

	// lowest set bit wins
	function automatic prn_t lowest_set(input logic [phys_regs-1:0] vec);
		prn_t idx;
		idx = '0;
		for (int p = phys_regs - 1; p >= 0; p--) begin
			if (vec[p]) begin
				idx = prn_t'(p);
			end
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// lookup and allocation
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			src_a_prn[i]   = rat[src_a_arn[i]];
			src_b_prn[i]   = rat[src_b_arn[i]];
			src_a_ready[i] = ready[rat[src_a_arn[i]]];
			src_b_ready[i] = ready[rat[src_b_arn[i]]];
		end
	end

	always_comb begin
		logic [phys_regs-1:0] pool;
		pool = free;
		for (int i = 0; i < ways; i++) begin
			granted[i]   = 1'b0;
			grant_prn[i] = '0;
			if (alloc_req[i] && |pool) begin
				granted[i]         = 1'b1;
				grant_prn[i]       = lowest_set(pool);
				pool[grant_prn[i]] = 1'b0;   // way 0 takes the lower tag
			end
		end
	end

	assign rename_stall = |(alloc_req & ~granted);   // all or nothing
	assign dest_prn     = grant_prn;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		rat_next   = rat;
		rrat_next  = rrat;
		ready_next = ready;
		free_next  = free;

		for (int i = 0; i < ways; i++) begin
			if (cdb_in[i].valid) begin
				ready_next[cdb_in[i].prn] = 1'b1;
			end
		end

		// way order, so the younger way owns a shared arn
		if (!rename_stall && !except) begin
			for (int i = 0; i < ways; i++) begin
				if (alloc_req[i]) begin
					rat_next[dest_arn[i]]   = grant_prn[i];
					free_next[grant_prn[i]]  = 1'b0;
					ready_next[grant_prn[i]] = 1'b0;
				end
			end
		end

		for (int i = 0; i < ways; i++) begin
			if (retire_in[i].valid) begin
				free_next[rrat_next[retire_in[i].arn]] = 1'b1;   // old copy is dead
				rrat_next[retire_in[i].arn]            = retire_in[i].prn;
			end
		end

		// flush back to the committed state
		if (except) begin
			rat_next   = rrat_next;
			ready_next = '0;
			free_next  = '1;
			for (int r = 0; r < arch_regs; r++) begin
				ready_next[rrat_next[r]] = 1'b1;
				free_next[rrat_next[r]]  = 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int r = 0; r < arch_regs; r++) begin
				rat[r]  <= prn_t'(r);
				rrat[r] <= prn_t'(r);
			end
			for (int p = 0; p < phys_regs; p++) begin
				ready[p] <= (p < arch_regs);
				free[p]  <= (p >= arch_regs);
			end
		end else begin
			rat   <= rat_next;
			rrat  <= rrat_next;
			ready <= ready_next;
			free  <= free_next;
		end
	end

endmodule

/* source/inst_decoder.sv */
// RV32IM instruction decoder
`timescale 1ns/100ps

module inst_decoder import rename_pkg::*; (
	input  if_id_packet_t if_packet,
	output decode_ctl_t   ctl
);

	inst_t   inst;
	opcode_e opcode;

	assign inst   = if_packet.inst;
	assign opcode = opcode_e'(inst.r.opcode);

	// shared funct3 map for op and op_imm
	function automatic alu_func_e base_func(input logic [2:0] funct3);
		alu_func_e f;
		case (funct3)
			3'b000:  f = alu_add;
			3'b001:  f = alu_sll;
			3'b010:  f = alu_slt;
			3'b011:  f = alu_sltu;
			3'b100:  f = alu_xor;
			3'b101:  f = alu_srl;
			3'b110:  f = alu_or;
			default: f = alu_and;
		endcase
		return f;
	endfunction

	always_comb begin
		// defaults decode as a nop
		ctl.opa_sel       = opa_rs1;
		ctl.opb_sel       = opb_rs2;
		ctl.dest_sel      = dest_none;
		ctl.alu_func      = alu_add;
		ctl.rd_mem        = 1'b0;
		ctl.wr_mem        = 1'b0;
		ctl.cond_branch   = 1'b0;
		ctl.uncond_branch = 1'b0;
		ctl.csr_op        = 1'b0;
		ctl.halt          = 1'b0;
		ctl.illegal       = 1'b0;

		if (if_packet.valid) begin
			case (opcode)
				opc_lui: begin
					ctl.dest_sel = dest_rd;
					ctl.opa_sel  = opa_zero;
					ctl.opb_sel  = opb_u_imm;
				end
				opc_auipc: begin
					ctl.dest_sel = dest_rd;
					ctl.opa_sel  = opa_pc;
					ctl.opb_sel  = opb_u_imm;
				end
				opc_jal: begin
					ctl.dest_sel      = dest_rd;
					ctl.opa_sel       = opa_pc;
					ctl.opb_sel       = opb_j_imm;
					ctl.uncond_branch = 1'b1;
				end
				opc_jalr: begin
					ctl.dest_sel      = dest_rd;
					ctl.opb_sel       = opb_i_imm;
					ctl.uncond_branch = 1'b1;
					ctl.illegal       = (inst.i.funct3 != 3'b000);
				end
				opc_branch: begin
					ctl.opa_sel     = opa_pc;   // target is pc relative
					ctl.opb_sel     = opb_b_imm;
					ctl.cond_branch = 1'b1;
					ctl.illegal     = (inst.b.funct3 inside {3'b010, 3'b011});
				end
				opc_load: begin
					ctl.dest_sel = dest_rd;
					ctl.opb_sel  = opb_i_imm;
					ctl.rd_mem   = 1'b1;
					ctl.illegal  = (inst.i.funct3 inside {3'b011, 3'b110, 3'b111});
				end
				opc_store: begin
					ctl.opb_sel = opb_s_imm;
					ctl.wr_mem  = 1'b1;
					ctl.illegal = (inst.s.funct3 > 3'b010);
				end
				opc_op_imm: begin
					ctl.dest_sel = dest_rd;
					ctl.opb_sel  = opb_i_imm;
					ctl.alu_func = base_func(inst.i.funct3);
					if (inst.i.funct3 == 3'b001) begin
						ctl.illegal = (inst.r.funct7 != 7'b0000000);   // slli
					end else if (inst.i.funct3 == 3'b101) begin
						if (inst.r.funct7 == 7'b0100000) begin
							ctl.alu_func = alu_sra;
						end else if (inst.r.funct7 != 7'b0000000) begin
							ctl.illegal = 1'b1;
						end
					end
				end
				opc_op: begin
					ctl.dest_sel = dest_rd;
					case (inst.r.funct7)
						7'b0000000: ctl.alu_func = base_func(inst.r.funct3);
						7'b0100000: begin
							if (inst.r.funct3 == 3'b000) begin
								ctl.alu_func = alu_sub;
							end else if (inst.r.funct3 == 3'b101) begin
								ctl.alu_func = alu_sra;
							end else begin
								ctl.illegal = 1'b1;
							end
						end
						7'b0000001: begin   // M extension, no divide unit here
							case (inst.r.funct3)
								3'b000:  ctl.alu_func = alu_mul;
								3'b001:  ctl.alu_func = alu_mulh;
								3'b010:  ctl.alu_func = alu_mulhsu;
								3'b011:  ctl.alu_func = alu_mulhu;
								default: ctl.illegal  = 1'b1;
							endcase
						end
						default: ctl.illegal = 1'b1;
					endcase
				end
				opc_system: begin
					if (inst == 32'h1050_0073) begin
						ctl.halt = 1'b1;   // wfi
					end else if (inst.i.funct3 inside {3'b001, 3'b010, 3'b011}) begin
						ctl.csr_op = 1'b1;
					end else begin
						ctl.illegal = 1'b1;
					end
				end
				default: ctl.illegal = 1'b1;
			endcase
		end

		ctl.valid = if_packet.valid & ~ctl.illegal & ~ctl.halt;
	end

endmodule

/* source/rename_pkg.sv */
// decode and rename types
package rename_pkg;

	parameter int xlen      = 32;   // data and instruction width
	parameter int arch_regs = 32;

	typedef logic [4:0] arn_t;
	typedef logic [5:0] prn_t;

	parameter int phys_regs = 2 ** $bits(prn_t);   // 64, fixed by the tag width

	////////////////////////////////////////////////////////////
	// instruction formats
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

	////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} alu_func_e;

	typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_e;

	typedef enum logic [2:0] {
		opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm
	} opb_sel_e;

	typedef enum logic {dest_none, dest_rd} dest_sel_e;

	////////////////////////////////////////////////////////////
	// stage packets
	////////////////////////////////////////////////////////////

	typedef struct packed {
		inst_t           inst;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic            valid;
	} if_id_packet_t;

	typedef struct packed {
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		dest_sel_e dest_sel;
		alu_func_e alu_func;
		logic      rd_mem;
		logic      wr_mem;
		logic      cond_branch;
		logic      uncond_branch;
		logic      csr_op;
		logic      halt;
		logic      illegal;
		logic      valid;
	} decode_ctl_t;

	typedef struct packed {
		inst_t           inst;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		decode_ctl_t     ctl;
		logic [xlen-1:0] rs1_value;   // holds the tag while not ready
		logic [xlen-1:0] rs2_value;
		logic            opa_ready;
		logic            opb_ready;
		prn_t            dest_prn;
		logic            valid;
	} id_ex_packet_t;

	typedef struct packed {
		prn_t            prn;
		logic [xlen-1:0] data;
		logic            valid;
	} cdb_packet_t;

	typedef struct packed {
		arn_t arn;
		prn_t prn;
		logic valid;
	} retire_packet_t;

endpackage
